// File: hw/mcr3_input_defines.svh
/*
  Widths and bit positions shared by the player-input RTL and testbench.
  Include wherever a control word, a port byte or a keyboard event is used.
*/
`ifndef MCR3_INPUT_DEFINES_SVH
`define MCR3_INPUT_DEFINES_SVH

// ====================================================================
// Player control word, active high, joystick words use the same layout
// ====================================================================
`define CTRL_W      10
`define CTRL_RIGHT  0
`define CTRL_LEFT   1
`define CTRL_DOWN   2
`define CTRL_UP     3
`define CTRL_FIRE_A 4
`define CTRL_FIRE_B 5
`define CTRL_FIRE_C 6
`define CTRL_FIRE_D 7
`define CTRL_START  8
`define CTRL_COIN   9

// Game CPU input port byte
`define PORT_W 8

// ====================================================================
// Keyboard event bus
// ====================================================================
`define KEY_W       11
`define KEY_TOGGLE  10
`define KEY_PRESSED 9
`define KEY_CODE_W  8

// Max RPM gearbox
`define GEAR_MAX    4
`define GEAR_CODE_W 4

`endif

// File: hw/mcr3_input_pkg.sv
/*
  Types for the player-input section: game selection, the keyboard
  scan codes the decoder reacts to, and the Max RPM gear code table.
*/
`include "mcr3_input_defines.svh"

package mcr3_input_pkg;

	// Selected game, NONE for any unsupported selection value
	typedef enum logic [2:0] {
		RAMPAGE    = 3'd0,
		SARGE      = 3'd1,
		POWERDRIVE = 3'd2,
		MAXRPM     = 3'd3,
		NONE       = 3'd7
	} game_t;

	// Set 2 scan codes used by the keyboard decoder
	typedef enum logic [`KEY_CODE_W-1:0] {
		KEY_UP     = 8'h75, KEY_DOWN  = 8'h72, KEY_LEFT  = 8'h6B, KEY_RIGHT = 8'h74,
		KEY_ESC    = 8'h76, KEY_F1    = 8'h05, KEY_F2    = 8'h06,
		KEY_LCTRL  = 8'h14, KEY_LALT  = 8'h11, KEY_SPACE = 8'h29, KEY_LSHIFT = 8'h12,
		KEY_1      = 8'h16, KEY_2     = 8'h1E, KEY_5     = 8'h2E, KEY_6     = 8'h36,
		KEY_7      = 8'h3D,
		KEY_R      = 8'h2D, KEY_F     = 8'h2B, KEY_D     = 8'h23, KEY_G     = 8'h34,
		KEY_A      = 8'h1C, KEY_S     = 8'h1B, KEY_Q     = 8'h21, KEY_W     = 8'h1D
	} key_code_t;

	// Gear index to the code the Max RPM shifter switch presents
	localparam logic [`GEAR_CODE_W-1:0] gear_code [0:`GEAR_MAX] = '{
		4'h0, 4'h5, 4'h6, 4'h1, 4'h2
	};

endpackage

// File: hw/control_decode.sv
/*
  Keyboard and joystick front end.
  Each make or break event sets or clears one held keyboard button. The
  held buttons are ORed with the joystick words into three active-high
  player control words. Player 3 only has a coin key on the keyboard.
*/
`timescale 1ns/1ps
`include "mcr3_input_defines.svh"

module control_decode
	import mcr3_input_pkg::*;
(
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [`KEY_W-1:0]   key_event,
	input  logic [`CTRL_W-1:0]  joy1,
	input  logic [`CTRL_W-1:0]  joy2,
	input  logic [`CTRL_W-1:0]  joy3,
	output logic [`CTRL_W-1:0]  p1_ctrl,
	output logic [`CTRL_W-1:0]  p2_ctrl,
	output logic [`CTRL_W-1:0]  p3_ctrl
);

	logic               toggle_q;
	logic               new_event;
	logic               pressed;
	logic [`CTRL_W-1:0] kb1;
	logic [`CTRL_W-1:0] kb2;
	logic               kb3_coin;
	logic [`CTRL_W-1:0] kb3;

	// A new event is flagged by a change of the toggle bit
	assign new_event = key_event[`KEY_TOGGLE] != toggle_q;
	assign pressed   = key_event[`KEY_PRESSED];

	always_ff @(posedge clk_sys) begin
		// Follow the toggle in reset too, so no stale event fires afterwards
		toggle_q <= key_event[`KEY_TOGGLE];
		if (reset) begin
			kb1      <= '0;
			kb2      <= '0;
			kb3_coin <= 1'b0;
		end else if (new_event) begin
			case (key_event[`KEY_CODE_W-1:0])
				// Player 1
				KEY_UP:     kb1[`CTRL_UP]     <= pressed;
				KEY_DOWN:   kb1[`CTRL_DOWN]   <= pressed;
				KEY_LEFT:   kb1[`CTRL_LEFT]   <= pressed;
				KEY_RIGHT:  kb1[`CTRL_RIGHT]  <= pressed;
				KEY_F1:     kb1[`CTRL_START]  <= pressed;
				KEY_1:      kb1[`CTRL_START]  <= pressed;
				KEY_ESC:    kb1[`CTRL_COIN]   <= pressed;
				KEY_5:      kb1[`CTRL_COIN]   <= pressed;
				KEY_LCTRL:  kb1[`CTRL_FIRE_A] <= pressed;
				KEY_LALT:   kb1[`CTRL_FIRE_B] <= pressed;
				KEY_SPACE:  kb1[`CTRL_FIRE_C] <= pressed;
				KEY_LSHIFT: kb1[`CTRL_FIRE_D] <= pressed;
				// Player 2, MAME style layout
				KEY_R:      kb2[`CTRL_UP]     <= pressed;
				KEY_F:      kb2[`CTRL_DOWN]   <= pressed;
				KEY_D:      kb2[`CTRL_LEFT]   <= pressed;
				KEY_G:      kb2[`CTRL_RIGHT]  <= pressed;
				KEY_F2:     kb2[`CTRL_START]  <= pressed;
				KEY_2:      kb2[`CTRL_START]  <= pressed;
				KEY_6:      kb2[`CTRL_COIN]   <= pressed;
				KEY_A:      kb2[`CTRL_FIRE_A] <= pressed;
				KEY_S:      kb2[`CTRL_FIRE_B] <= pressed;
				KEY_Q:      kb2[`CTRL_FIRE_C] <= pressed;
				KEY_W:      kb2[`CTRL_FIRE_D] <= pressed;
				// Player 3
				KEY_7:      kb3_coin          <= pressed;
				default: ;
			endcase
		end
	end

	always_comb begin
		kb3             = '0;
		kb3[`CTRL_COIN] = kb3_coin;
	end

	// ====================================================================
	// Merge with joysticks
	// ====================================================================
	assign p1_ctrl = kb1 | joy1;
	assign p2_ctrl = kb2 | joy2;
	assign p3_ctrl = kb3 | joy3;

endmodule

// File: hw/gear_shift.sv
/*
  Gear state for the driving games.
  Max RPM has a five-position shifter per player stepped by fire A and
  fire B and reset by start. Power Drive has a two-position gear per
  player flipped by fire D. All steps act on rising edges.
*/
`timescale 1ns/1ps
`include "mcr3_input_defines.svh"

module gear_shift
	import mcr3_input_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic [`CTRL_W-1:0]       p1_ctrl,
	input  logic [`CTRL_W-1:0]       p2_ctrl,
	input  logic [`CTRL_W-1:0]       p3_ctrl,
	output logic [`GEAR_CODE_W-1:0]  maxrpm_gear1,
	output logic [`GEAR_CODE_W-1:0]  maxrpm_gear2,
	output logic [2:0]               powerdrv_gear
);

	localparam int GEAR_IDX_W = $clog2(`GEAR_MAX + 1);
	localparam logic [GEAR_IDX_W-1:0] GEAR_TOP = `GEAR_MAX;

	logic [1:0]            start;
	logic [1:0]            fire_a;
	logic [1:0]            fire_b;
	logic [2:0]            fire_d;
	logic [1:0]            fire_a_q;
	logic [1:0]            fire_b_q;
	logic [2:0]            fire_d_q;
	logic [1:0]            rise_a;
	logic [1:0]            rise_b;
	logic [2:0]            rise_d;
	logic [GEAR_IDX_W-1:0] gear_idx [2];

	assign start  = {p2_ctrl[`CTRL_START], p1_ctrl[`CTRL_START]};
	assign fire_a = {p2_ctrl[`CTRL_FIRE_A], p1_ctrl[`CTRL_FIRE_A]};
	assign fire_b = {p2_ctrl[`CTRL_FIRE_B], p1_ctrl[`CTRL_FIRE_B]};
	assign fire_d = {p3_ctrl[`CTRL_FIRE_D], p2_ctrl[`CTRL_FIRE_D], p1_ctrl[`CTRL_FIRE_D]};

	// Previous-cycle fire bits, tracked through reset as well
	always_ff @(posedge clk_sys) begin
		fire_a_q <= fire_a;
		fire_b_q <= fire_b;
		fire_d_q <= fire_d;
	end

	assign rise_a = fire_a & ~fire_a_q;
	assign rise_b = fire_b & ~fire_b_q;
	assign rise_d = fire_d & ~fire_d_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gear_idx[0]   <= '0;
			gear_idx[1]   <= '0;
			powerdrv_gear <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				// Start wins over shifting, up wins over down
				if (start[i])
					gear_idx[i] <= '0;
				else if (rise_a[i] && gear_idx[i] != GEAR_TOP)
					gear_idx[i] <= gear_idx[i] + 1'b1;
				else if (rise_b[i] && gear_idx[i] != '0)
					gear_idx[i] <= gear_idx[i] - 1'b1;
			end
			powerdrv_gear <= powerdrv_gear ^ rise_d;
		end
	end

	assign maxrpm_gear1 = gear_code[gear_idx[0]];
	assign maxrpm_gear2 = gear_code[gear_idx[1]];

endmodule

// File: hw/input_port_mux.sv
/*
  Builds the five input port bytes read by the game CPU.
  The game is latched from game_sel on a game_load strobe. Port 3 is the
  DIP byte, the others are active-low and laid out per game. Ports a game
  does not use, and every port under NONE, read all ones.
*/
`timescale 1ns/1ps
`include "mcr3_input_defines.svh"

module input_port_mux
	import mcr3_input_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     game_load,
	input  logic [`PORT_W-1:0]       game_sel,
	input  logic [`CTRL_W-1:0]       p1_ctrl,
	input  logic [`CTRL_W-1:0]       p2_ctrl,
	input  logic [`CTRL_W-1:0]       p3_ctrl,
	input  logic [`GEAR_CODE_W-1:0]  maxrpm_gear1,
	input  logic [`GEAR_CODE_W-1:0]  maxrpm_gear2,
	input  logic [2:0]               powerdrv_gear,
	input  logic [`PORT_W-1:0]       dip_sw,
	input  logic                     test_sw,
	input  logic                     twin_stick_mode,
	output logic [`PORT_W-1:0]       input0,
	output logic [`PORT_W-1:0]       input1,
	output logic [`PORT_W-1:0]       input2,
	output logic [`PORT_W-1:0]       input3,
	output logic [`PORT_W-1:0]       input4
);

	game_t game;
	logic  coin_all;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game <= RAMPAGE;
		end else if (game_load) begin
			case (game_sel)
				`PORT_W'(0): game <= RAMPAGE;
				`PORT_W'(1): game <= SARGE;
				`PORT_W'(2): game <= POWERDRIVE;
				`PORT_W'(3): game <= MAXRPM;
				default:     game <= NONE;
			endcase
		end
	end

	// Rampage player byte, active high
	function automatic logic [`PORT_W-1:0] rampage_byte(input logic [`CTRL_W-1:0] c);
		return {2'b00, c[`CTRL_FIRE_B], c[`CTRL_FIRE_A],
			c[`CTRL_LEFT], c[`CTRL_DOWN], c[`CTRL_RIGHT], c[`CTRL_UP]};
	endfunction

	// Sarge player byte, the twin sticks folded out of one joystick
	function automatic logic [`PORT_W-1:0] sarge_byte(input logic [`CTRL_W-1:0] c,
		input logic twin);
		logic lu;
		logic ld;
		logic ru;
		logic rd;
		lu = twin ? (c[`CTRL_UP] | c[`CTRL_RIGHT]) : c[`CTRL_UP];
		ld = twin ? (c[`CTRL_DOWN] | c[`CTRL_LEFT]) : c[`CTRL_DOWN];
		ru = twin ? (c[`CTRL_UP] | c[`CTRL_LEFT]) : c[`CTRL_FIRE_C];
		rd = twin ? (c[`CTRL_DOWN] | c[`CTRL_RIGHT]) : c[`CTRL_FIRE_B];
		return {c[`CTRL_FIRE_D], c[`CTRL_FIRE_D], c[`CTRL_FIRE_A], c[`CTRL_FIRE_A],
			rd, ru, ld, lu};
	endfunction

	assign coin_all = p1_ctrl[`CTRL_COIN] | p2_ctrl[`CTRL_COIN] | p3_ctrl[`CTRL_COIN];
	assign input3   = dip_sw;

	always_comb begin
		input0 = '1;
		input1 = '1;
		input2 = '1;
		input4 = '1;
		case (game)
			RAMPAGE: begin
				input0 = ~{2'b00, test_sw, 1'b0, 2'b00, 1'b0, coin_all};
				input1 = ~rampage_byte(p1_ctrl);
				input2 = ~rampage_byte(p2_ctrl);
				input4 = ~rampage_byte(p3_ctrl);
			end
			SARGE: begin
				input0 = ~{2'b00, test_sw, 1'b0, p2_ctrl[`CTRL_START],
					p1_ctrl[`CTRL_START], 1'b0, coin_all};
				input1 = ~sarge_byte(p1_ctrl, twin_stick_mode);
				input2 = ~sarge_byte(p2_ctrl, twin_stick_mode);
			end
			POWERDRIVE: begin
				// Separate coin per player here
				input0 = ~{2'b00, test_sw, 2'b00, p3_ctrl[`CTRL_COIN],
					p2_ctrl[`CTRL_COIN], p1_ctrl[`CTRL_COIN]};
				input1 = ~{p2_ctrl[`CTRL_FIRE_B], p2_ctrl[`CTRL_FIRE_A], powerdrv_gear[1],
					p2_ctrl[`CTRL_FIRE_C], p1_ctrl[`CTRL_FIRE_B], p1_ctrl[`CTRL_FIRE_A],
					powerdrv_gear[0], p1_ctrl[`CTRL_FIRE_C]};
				input2 = ~{4'b0000, p3_ctrl[`CTRL_FIRE_B], p3_ctrl[`CTRL_FIRE_A],
					powerdrv_gear[2], p3_ctrl[`CTRL_FIRE_C]};
			end
			MAXRPM: begin
				// Port 1 is the pedal ADC on the board, unused so left at ones
				input0 = ~{test_sw, 3'b000, p1_ctrl[`CTRL_START], p2_ctrl[`CTRL_START],
					coin_all, 1'b0};
				input2 = ~{maxrpm_gear1, maxrpm_gear2};
			end
			default: ;
		endcase
	end

endmodule

// File: hw/mcr3_input_top.sv
/*
  Player-input section top level.
  The keyboard decoder and the gear block run side by side off the same
  control words and both feed the port multiplexer.
*/
`timescale 1ns/1ps
`include "mcr3_input_defines.svh"

module mcr3_input_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [`KEY_W-1:0]   key_event,
	input  logic [`CTRL_W-1:0]  joy1,
	input  logic [`CTRL_W-1:0]  joy2,
	input  logic [`CTRL_W-1:0]  joy3,
	input  logic                game_load,
	input  logic [`PORT_W-1:0]  game_sel,
	input  logic [`PORT_W-1:0]  dip_sw,
	input  logic                test_sw,
	input  logic                twin_stick_mode,
	output logic [`PORT_W-1:0]  input0,
	output logic [`PORT_W-1:0]  input1,
	output logic [`PORT_W-1:0]  input2,
	output logic [`PORT_W-1:0]  input3,
	output logic [`PORT_W-1:0]  input4
);

	logic [`CTRL_W-1:0]      p1_ctrl;
	logic [`CTRL_W-1:0]      p2_ctrl;
	logic [`CTRL_W-1:0]      p3_ctrl;
	logic [`GEAR_CODE_W-1:0] maxrpm_gear1;
	logic [`GEAR_CODE_W-1:0] maxrpm_gear2;
	logic [2:0]              powerdrv_gear;

	control_decode control_decode_i (
		.clk_sys, .reset, .key_event, .joy1, .joy2, .joy3,
		.p1_ctrl, .p2_ctrl, .p3_ctrl
	);

	gear_shift gear_shift_i (
		.clk_sys, .reset, .p1_ctrl, .p2_ctrl, .p3_ctrl,
		.maxrpm_gear1, .maxrpm_gear2, .powerdrv_gear
	);

	input_port_mux input_port_mux_i (
		.clk_sys, .reset, .game_load, .game_sel,
		.p1_ctrl, .p2_ctrl, .p3_ctrl,
		.maxrpm_gear1, .maxrpm_gear2, .powerdrv_gear,
		.dip_sw, .test_sw, .twin_stick_mode,
		.input0, .input1, .input2, .input3, .input4
	);

endmodule

// File: tb/mcr3_input_sva.sv
/*
  Concurrent checks bound into the player-input top level.
  Port 3 mirrors the DIP byte, reset clears the Max RPM gears and the
  gear codes stay inside the shifter table.
*/
`timescale 1ns/1ps
`include "mcr3_input_defines.svh"

module mcr3_input_sva (
	input logic                    clk_sys,
	input logic                    reset,
	input logic [`PORT_W-1:0]      dip_sw,
	input logic [`PORT_W-1:0]      input3,
	input logic [`GEAR_CODE_W-1:0] maxrpm_gear1,
	input logic [`GEAR_CODE_W-1:0] maxrpm_gear2
);

	// Number of failed checks
	int error_count = 0;

	// Port 3 is wired straight from the DIP switches
	port3_is_dip: assert property (@(posedge clk_sys) input3 == dip_sw)
		else begin
			$error("Input port 3 %h differs from dip_sw %h", input3, dip_sw);
			error_count++;
		end

	// Reset puts both shifters in gear index 0
	reset_clears_gears: assert property (@(posedge clk_sys)
		reset |=> (maxrpm_gear1 == 4'h0 && maxrpm_gear2 == 4'h0))
		else begin
			$error("Max RPM gear codes not cleared after reset");
			error_count++;
		end

	// ====================================================================
	// Only the five shifter codes may appear
	// ====================================================================
	gear1_in_table: assert property (@(posedge clk_sys) disable iff (reset)
		maxrpm_gear1 inside {4'h0, 4'h5, 4'h6, 4'h1, 4'h2})
		else begin
			$error("Max RPM gear 1 code %h outside the table", maxrpm_gear1);
			error_count++;
		end

	gear2_in_table: assert property (@(posedge clk_sys) disable iff (reset)
		maxrpm_gear2 inside {4'h0, 4'h5, 4'h6, 4'h1, 4'h2})
		else begin
			$error("Max RPM gear 2 code %h outside the table", maxrpm_gear2);
			error_count++;
		end

endmodule

bind mcr3_input_top mcr3_input_sva mcr3_input_sva_i (
	.clk_sys(clk_sys),
	.reset(reset),
	.dip_sw(dip_sw),
	.input3(input3),
	.maxrpm_gear1(maxrpm_gear1),
	.maxrpm_gear2(maxrpm_gear2)
);

// File: tb/mcr3_input_tb.sv
/*
  Testbench for the player-input section.
  Drives keyboard events, joysticks and game loads on falling clock edges
  and checks the port bytes with immediate assertions against expected
  bytes built from the per-game port layouts. One line per test, then
  the counts and the final verdict.
*/
`timescale 1ns/1ps
`include "mcr3_input_defines.svh"

module mcr3_input_tb
	import mcr3_input_pkg::*;
();

	logic               clk_sys;
	logic               reset;
	logic [`KEY_W-1:0]  key_event;
	logic [`CTRL_W-1:0] joy1;
	logic [`CTRL_W-1:0] joy2;
	logic [`CTRL_W-1:0] joy3;
	logic               game_load;
	logic [`PORT_W-1:0] game_sel;
	logic [`PORT_W-1:0] dip_sw;
	logic               test_sw;
	logic               twin_stick_mode;
	logic [`PORT_W-1:0] input0;
	logic [`PORT_W-1:0] input1;
	logic [`PORT_W-1:0] input2;
	logic [`PORT_W-1:0] input3;
	logic [`PORT_W-1:0] input4;

	integer      seed;
	int          errors;
	int          checks;
	int          tests;
	int          g [2];
	logic [2:0]  pd;
	logic [31:0] rnd;

	// Shifter codes for gear index 0 to 4
	localparam logic [3:0] gear_codes [0:4] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};
	// Up past the top, down twice, start, then down at the bottom
	localparam int rpm_steps [0:8] = '{`CTRL_FIRE_A, `CTRL_FIRE_A, `CTRL_FIRE_A,
		`CTRL_FIRE_A, `CTRL_FIRE_A, `CTRL_FIRE_B, `CTRL_FIRE_B, `CTRL_START, `CTRL_FIRE_B};

	mcr3_input_top mcr3_input_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ====================================================================
	// Expected port bytes
	// ====================================================================
	function automatic logic [`PORT_W-1:0] exp_rampage(input logic [`CTRL_W-1:0] c);
		return ~{2'b00, c[`CTRL_FIRE_B], c[`CTRL_FIRE_A], c[`CTRL_LEFT], c[`CTRL_DOWN],
			c[`CTRL_RIGHT], c[`CTRL_UP]};
	endfunction

	function automatic logic [`PORT_W-1:0] exp_sarge(input logic [`CTRL_W-1:0] c,
		input logic twin);
		logic [3:0] stick;
		if (twin) begin
			// rd, ru, ld, lu from the one joystick
			stick = {c[`CTRL_DOWN] | c[`CTRL_RIGHT], c[`CTRL_UP] | c[`CTRL_LEFT],
				c[`CTRL_DOWN] | c[`CTRL_LEFT], c[`CTRL_UP] | c[`CTRL_RIGHT]};
		end else begin
			stick = {c[`CTRL_FIRE_B], c[`CTRL_FIRE_C], c[`CTRL_DOWN], c[`CTRL_UP]};
		end
		return ~{{2{c[`CTRL_FIRE_D]}}, {2{c[`CTRL_FIRE_A]}}, stick};
	endfunction

	function automatic logic [`PORT_W-1:0] port_value(input int idx);
		case (idx)
			0: return input0;
			1: return input1;
			2: return input2;
			default: return input4;
		endcase
	endfunction

	task automatic check_port(input string what, input logic [`PORT_W-1:0] actual,
		input logic [`PORT_W-1:0] expected);
		checks++;
		assert (actual === expected) else begin
			$display("Fail %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %0d (%s) finished, %0d errors so far", tests, name, errors);
	endtask

	task automatic load_game(input logic [`PORT_W-1:0] sel);
		@(negedge clk_sys);
		game_sel = sel;
		game_load = 1'b1;
		@(negedge clk_sys);
		game_load = 1'b0;
		#1;
	endtask

	task automatic set_ctrl(input int player, input int pos, input logic val);
		@(negedge clk_sys);
		case (player)
			0: joy1[pos] = val;
			1: joy2[pos] = val;
			default: joy3[pos] = val;
		endcase
		#1;
	endtask

	task automatic pulse_ctrl(input int player, input int pos);
		set_ctrl(player, pos, 1'b1);
		set_ctrl(player, pos, 1'b0);
	endtask

	// Waits for a port value, then checks it took exactly one edge
	task automatic wait_port(input int idx, input logic [`PORT_W-1:0] expected);
		int taken;
		taken = 0;
		#1;
		while (port_value(idx) !== expected && taken < 8) begin
			@(negedge clk_sys);
			taken++;
		end
		checks++;
		if (port_value(idx) !== expected) begin
			$display("Timeout: port %0d never reached %h within 8 cycles", idx, expected);
			errors++;
		end else begin
			assert (taken == 1) else begin
				$display("Fail %0d ns: port %0d took %0d edges", $time, idx, taken);
				errors++;
			end
		end
	endtask

	task automatic key_check(input key_code_t code, input int idx,
		input logic [`PORT_W-1:0] pressed_val);
		@(negedge clk_sys);
		key_event = {~key_event[`KEY_TOGGLE], 1'b1, 1'b0, code};
		wait_port(idx, pressed_val);
		@(negedge clk_sys);
		key_event = {~key_event[`KEY_TOGGLE], 1'b0, 1'b0, code};
		wait_port(idx, 8'hFF);
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================
	initial begin
		seed = 41313;
		errors = 0;
		checks = 0;
		tests = 0;
		reset = 1'b1;
		key_event = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		game_load = 1'b0;
		game_sel = '0;
		dip_sw = 8'hA5;
		test_sw = 1'b0;
		twin_stick_mode = 1'b0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		#1;

		check_port("reset port 0", input0, 8'hFF);
		check_port("reset port 1", input1, 8'hFF);
		check_port("reset port 2", input2, 8'hFF);
		check_port("reset port 4", input4, 8'hFF);
		check_port("port 3", input3, dip_sw);
		@(negedge clk_sys);
		test_sw = 1'b1;
		#1;
		check_port("rampage test bit", input0, 8'hDF);
		end_test("reset and rampage defaults");

		repeat (4) begin
			@(negedge clk_sys);
			test_sw = 1'b0;
			rnd = $random(seed);
			joy1 = rnd[`CTRL_W-1:0];
			rnd = $random(seed);
			joy2 = rnd[`CTRL_W-1:0];
			rnd = $random(seed);
			joy3 = rnd[`CTRL_W-1:0];
			#1;
			check_port("rampage port 1", input1, exp_rampage(joy1));
			check_port("rampage port 2", input2, exp_rampage(joy2));
			check_port("rampage port 4", input4, exp_rampage(joy3));
			check_port("rampage coin", input0,
				~{7'b0, joy1[`CTRL_COIN] | joy2[`CTRL_COIN] | joy3[`CTRL_COIN]});
		end
		@(negedge clk_sys);
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		key_check(KEY_LCTRL, 1, ~8'h10);
		key_check(KEY_UP, 1, ~8'h01);
		key_check(KEY_R, 2, ~8'h01);
		key_check(KEY_S, 2, ~8'h20);
		key_check(KEY_7, 0, ~8'h01);
		key_check(KEY_5, 0, ~8'h01);
		end_test("keyboard and joystick mapping");

		load_game(8'd1);
		for (int twin = 0; twin < 2; twin++) begin
			repeat (4) begin
				@(negedge clk_sys);
				twin_stick_mode = twin[0];
				rnd = $random(seed);
				joy1 = rnd[`CTRL_W-1:0];
				rnd = $random(seed);
				joy2 = rnd[`CTRL_W-1:0];
				#1;
				check_port("sarge port 1", input1, exp_sarge(joy1, twin_stick_mode));
				check_port("sarge port 2", input2, exp_sarge(joy2, twin_stick_mode));
			end
		end
		end_test("sarge twin-stick mapping");

		// Fresh reset so the Power Drive gears start from zero
		@(negedge clk_sys);
		reset = 1'b1;
		joy1 = '0;
		joy2 = '0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		load_game(8'd2);
		pd = '0;
		for (int i = 0; i < 6; i++) begin
			pulse_ctrl(i % 3, `CTRL_FIRE_D);
			pd[i % 3] = ~pd[i % 3];
			check_port("power drive port 1", input1, ~{2'b00, pd[1], 3'b000, pd[0], 1'b0});
			check_port("power drive port 2", input2, ~{6'b000000, pd[2], 1'b0});
		end
		for (int p = 0; p < 3; p++) begin
			set_ctrl(p, `CTRL_COIN, 1'b1);
			check_port("power drive coin", input0, ~(8'h01 << p));
			set_ctrl(p, `CTRL_COIN, 1'b0);
		end
		end_test("power drive gear toggles");

		load_game(8'd3);
		g[0] = 0;
		g[1] = 0;
		for (int p = 0; p < 2; p++) begin
			for (int s = 0; s < 9; s++) begin
				pulse_ctrl(p, rpm_steps[s]);
				if (rpm_steps[s] == `CTRL_START)
					g[p] = 0;
				else if (rpm_steps[s] == `CTRL_FIRE_A && g[p] < `GEAR_MAX)
					g[p]++;
				else if (rpm_steps[s] == `CTRL_FIRE_B && g[p] > 0)
					g[p]--;
				check_port("max rpm port 2", input2, ~{gear_codes[g[0]], gear_codes[g[1]]});
				check_port("max rpm port 1", input1, 8'hFF);
			end
		end
		end_test("max rpm gearbox");

		@(negedge clk_sys);
		test_sw = 1'b1;
		joy1 = '1;
		joy2 = '1;
		joy3 = '1;
		load_game(8'd7);
		check_port("none port 0", input0, 8'hFF);
		check_port("none port 1", input1, 8'hFF);
		check_port("none port 2", input2, 8'hFF);
		check_port("none port 4", input4, 8'hFF);
		end_test("unsupported selection");

		// Concurrent assertion failures count as errors too
		errors += mcr3_input_top_i.mcr3_input_sva_i.error_count;
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/mcr3_input_pkg.sv
hw/control_decode.sv
hw/gear_shift.sv
hw/input_port_mux.sv
hw/mcr3_input_top.sv
tb/mcr3_input_sva.sv
tb/mcr3_input_tb.sv

// File: Makefile
# Verilator build and run for the player-input section
# Any variable can be overridden on the command line, e.g. make simulate LOG=run.log

VERILATOR ?= verilator
TOP       ?= mcr3_input_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
